// ==== rtl/timer_pkg.sv ====
// Shared types, register map and APB structs for the two-channel APB timer.
// Modules import it with a wildcard in the body and use scoped names in ports.

package timer_pkg;

   // Value widths
   typedef logic [31:0] count_t;        // Counter and compare value
   typedef logic [7:0]  presc_t;        // Prescale divide value
   typedef logic [11:0] apb_addr_t;     // APB byte address
   typedef logic [31:0] apb_data_t;     // APB data word

   localparam int unsigned N_CHAN = 2;  // lo is bit 0, hi is bit 1 in status and mask

   // Master-driven APB signals
   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   // Slave-driven APB signals
   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // One channel's configuration, as driven by the register block
   typedef struct packed {
      logic   enable;                   // Prescaler runs
      logic   clear;                    // One-cycle restart of prescaler and counter
      presc_t prescale;                 // Divide value D, one tick every D+1 cycles
      count_t compare;                  // Wrap point of the counter
   } chan_cfg_t;

   // Register map
   localparam apb_addr_t ADDR_CTRL       = 12'h000;
   localparam apb_addr_t ADDR_PRESC_LO   = 12'h004;
   localparam apb_addr_t ADDR_PRESC_HI   = 12'h008;
   localparam apb_addr_t ADDR_CMP_LO     = 12'h00C;
   localparam apb_addr_t ADDR_CMP_HI     = 12'h010;
   localparam apb_addr_t ADDR_CNT_LO     = 12'h014; // Read only
   localparam apb_addr_t ADDR_CNT_HI     = 12'h018; // Read only
   localparam apb_addr_t ADDR_IRQ_STATUS = 12'h01C; // Write one to clear
   localparam apb_addr_t ADDR_IRQ_MASK   = 12'h020;

   // CTRL bit positions, the lower three are stored
   localparam int unsigned CTRL_EN_LO   = 0;
   localparam int unsigned CTRL_EN_HI   = 1;
   localparam int unsigned CTRL_CASCADE = 2;
   localparam int unsigned CTRL_CLR_LO  = 3;  // Self-clearing, reads 0
   localparam int unsigned CTRL_CLR_HI  = 4;  // Self-clearing, reads 0

endpackage : timer_pkg

// ==== rtl/timer_prescaler.sv ====
// Programmable divider on hclk. Emits a one-cycle tick every divide+1 cycles
// while enabled; a clear or a disable restarts the division from zero.

module timer_prescaler (
   input  logic              hclk,
   input  logic              arst_n,
   input  logic              enable,   // Run the divider
   input  logic              clear,    // Restart pulse from the register block
   input  timer_pkg::presc_t divide,   // Divide value D
   output logic              tick      // High in the cycle the count equals D
);

   import timer_pkg::*;

   presc_t div_cnt;                    // Internal division count
   presc_t div_nxt;
   logic   running;                    // Enabled and not being cleared

   assign running = enable && !clear;

   // Combinational so the counter steps at the same edge the divider wraps
   assign tick = running && (div_cnt == divide);

   always_comb begin
      div_nxt = div_cnt;
      if (!running) begin
         div_nxt = '0;                 // Held at zero while stopped
      end else if (tick) begin
         div_nxt = '0;                 // Wrap after reaching D
      end else begin
         div_nxt = div_cnt + 1'b1;
      end
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_nxt;
      end
   end

endmodule : timer_prescaler

// ==== rtl/timer_counter.sv ====
// 32-bit compare counter. Advances on step, wraps to zero on a compare match
// and reports the match as a one-cycle pulse for status and cascade.

module timer_counter (
   input  logic              hclk,
   input  logic              arst_n,
   input  logic              step,     // Tick from prescaler or lo match in cascade
   input  logic              clear,    // Forces zero, wins over step
   input  timer_pkg::count_t compare,  // Wrap point
   output timer_pkg::count_t count,    // Current value, readable over APB
   output logic              match     // Step taken while at compare
);

   import timer_pkg::*;

   count_t count_nxt;                  // Next count value
   logic   at_compare;                 // Count sits on the compare value

   assign at_compare = (count == compare);

   // Combinational so status and the cascaded hi counter act at the same edge
   assign match = step && at_compare;

   always_comb begin
      count_nxt = count;
      if (clear) begin
         count_nxt = '0;               // Clear pulse overrides any step
      end else if (match) begin
         count_nxt = '0;               // Wrap instead of incrementing
      end else if (step) begin
         count_nxt = count + 1'b1;
      end
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else begin
         count <= count_nxt;
      end
   end

   // A compare of zero gives a match on every step and the count stays at 0
   // A compare lowered below the count lets it run through the full 32-bit range

endmodule : timer_counter

// ==== rtl/timer_apb_regs.sv ====
// APB register block of the timer. Holds control, prescale, compare, status
// and mask, drives both channel configs and the registered interrupt.

module timer_apb_regs (
   input  logic                 hclk,
   input  logic                 arst_n,
   input  timer_pkg::apb_req_t  apb_req,
   output timer_pkg::apb_rsp_t  apb_rsp,
   output timer_pkg::chan_cfg_t cfg_lo,
   output timer_pkg::chan_cfg_t cfg_hi,
   output logic                 cascade,   // hi counter steps on lo matches
   input  timer_pkg::count_t    count_lo,
   input  timer_pkg::count_t    count_hi,
   input  logic                 match_lo,
   input  logic                 match_hi,
   output logic                 irq        // OR of unmasked status, registered
);

   import timer_pkg::*;

   logic                    access;        // Access phase of a transfer
   logic                    rd_en;
   logic                    wr_en;         // Legal write, takes effect at this edge
   logic                    addr_hit;      // Address is in the map
   logic                    cnt_addr;      // One of the read-only count registers
   apb_data_t               rdata;         // Read mux output

   logic [CTRL_CASCADE:0]   ctrl_q;        // en_lo, en_hi, cascade
   logic [N_CHAN-1:0]       clr_q;         // Clear pulses, lo in bit 0
   presc_t                  presc_lo_q;
   presc_t                  presc_hi_q;
   count_t                  cmp_lo_q;
   count_t                  cmp_hi_q;
   logic [N_CHAN-1:0]       status_q;      // Sticky match flags
   logic [N_CHAN-1:0]       status_d;
   logic [N_CHAN-1:0]       status_w1c;    // Bits cleared by this write
   logic [N_CHAN-1:0]       mask_q;
   logic                    irq_q;

   // Transfer phases
   assign access = apb_req.psel && apb_req.penable;
   assign rd_en  = access && !apb_req.pwrite;

   // Address decode and read data
   always_comb begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (apb_req.paddr)
         ADDR_CTRL:       rdata = apb_data_t'(ctrl_q);      // Clear bits read 0
         ADDR_PRESC_LO:   rdata = apb_data_t'(presc_lo_q);
         ADDR_PRESC_HI:   rdata = apb_data_t'(presc_hi_q);
         ADDR_CMP_LO:     rdata = cmp_lo_q;
         ADDR_CMP_HI:     rdata = cmp_hi_q;
         ADDR_CNT_LO:     rdata = count_lo;
         ADDR_CNT_HI:     rdata = count_hi;
         ADDR_IRQ_STATUS: rdata = apb_data_t'(status_q);
         ADDR_IRQ_MASK:   rdata = apb_data_t'(mask_q);
         default:         addr_hit = 1'b0;
      endcase
   end

   assign cnt_addr = (apb_req.paddr == ADDR_CNT_LO) || (apb_req.paddr == ADDR_CNT_HI);
   assign wr_en    = access && apb_req.pwrite && addr_hit && !cnt_addr;

   // Zero wait states, error in the access phase only
   assign apb_rsp.prdata  = rd_en ? rdata : '0;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && (!addr_hit || (apb_req.pwrite && cnt_addr));

   // Status, a match in the same cycle beats a write-one-to-clear
   always_comb begin
      status_w1c = '0;
      if (wr_en && (apb_req.paddr == ADDR_IRQ_STATUS)) begin
         status_w1c = apb_req.pwdata[N_CHAN-1:0];
      end
      status_d = (status_q & ~status_w1c) | {match_hi, match_lo};
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_q     <= '0;
         clr_q      <= '0;
         presc_lo_q <= '0;
         presc_hi_q <= '0;
         cmp_lo_q   <= '0;
         cmp_hi_q   <= '0;
         status_q   <= '0;
         mask_q     <= '0;
         irq_q      <= 1'b0;
      end else begin
         clr_q <= '0;                                          // Pulses last one cycle
         if (wr_en) begin
            case (apb_req.paddr)
               ADDR_CTRL: begin
                  ctrl_q <= apb_req.pwdata[CTRL_CASCADE:0];
                  clr_q  <= {apb_req.pwdata[CTRL_CLR_HI], apb_req.pwdata[CTRL_CLR_LO]};
               end
               ADDR_PRESC_LO: presc_lo_q <= presc_t'(apb_req.pwdata);
               ADDR_PRESC_HI: presc_hi_q <= presc_t'(apb_req.pwdata);
               ADDR_CMP_LO:   cmp_lo_q   <= apb_req.pwdata;
               ADDR_CMP_HI:   cmp_hi_q   <= apb_req.pwdata;
               ADDR_IRQ_MASK: mask_q     <= apb_req.pwdata[N_CHAN-1:0];
               default:       ;                                // Status handled above
            endcase
         end
         status_q <= status_d;
         irq_q    <= |(status_q & mask_q);                     // One cycle behind status
      end
   end

   assign irq = irq_q;

   // Channel configs, all fields come straight from flops
   assign cfg_lo = '{
      enable:   ctrl_q[CTRL_EN_LO],
      clear:    clr_q[0],
      prescale: presc_lo_q,
      compare:  cmp_lo_q
   };

   assign cfg_hi = '{
      enable:   ctrl_q[CTRL_EN_HI],
      clear:    clr_q[1],
      prescale: presc_hi_q,
      compare:  cmp_hi_q
   };

   assign cascade = ctrl_q[CTRL_CASCADE];

endmodule : timer_apb_regs

// ==== rtl/apb_timer_ss.sv ====
// Top of the two-channel APB timer: register block, two prescalers and two
// compare counters. The hi counter can be cascaded onto lo matches.

module apb_timer_ss (
   input  logic                hclk,
   input  logic                arst_n,
   input  timer_pkg::apb_req_t apb_req,
   output timer_pkg::apb_rsp_t apb_rsp,
   output logic                irq
);

   import timer_pkg::*;

   chan_cfg_t cfg_lo;
   chan_cfg_t cfg_hi;
   logic      cascade;
   logic      tick_lo;
   logic      tick_hi;     // Ignored while cascaded
   logic      step_hi;
   count_t    count_lo;
   count_t    count_hi;
   logic      match_lo;
   logic      match_hi;

   // hi counts lo wraps in cascade, its own ticks otherwise
   assign step_hi = cascade ? match_lo : tick_hi;

   timer_apb_regs regs_i (
      .hclk    (hclk),
      .arst_n  (arst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .cfg_lo  (cfg_lo),
      .cfg_hi  (cfg_hi),
      .cascade (cascade),
      .count_lo(count_lo),
      .count_hi(count_hi),
      .match_lo(match_lo),
      .match_hi(match_hi),
      .irq     (irq)
   );

   timer_prescaler presc_lo_i (
      .hclk  (hclk),
      .arst_n(arst_n),
      .enable(cfg_lo.enable),
      .clear (cfg_lo.clear),
      .divide(cfg_lo.prescale),
      .tick  (tick_lo)
   );

   timer_prescaler presc_hi_i (
      .hclk  (hclk),
      .arst_n(arst_n),
      .enable(cfg_hi.enable),
      .clear (cfg_hi.clear),
      .divide(cfg_hi.prescale),
      .tick  (tick_hi)
   );

   timer_counter cnt_lo_i (
      .hclk   (hclk),
      .arst_n (arst_n),
      .step   (tick_lo),
      .clear  (cfg_lo.clear),
      .compare(cfg_lo.compare),
      .count  (count_lo),
      .match  (match_lo)
   );

   timer_counter cnt_hi_i (
      .hclk   (hclk),
      .arst_n (arst_n),
      .step   (step_hi),
      .clear  (cfg_hi.clear),
      .compare(cfg_hi.compare),
      .count  (count_hi),
      .match  (match_hi)
   );

endmodule : apb_timer_ss

// ==== testbench/tb_apb_timer_ss.sv ====
// Self-checking testbench of the two-channel APB timer.
// Drives APB transfers with random values and checks against a cycle model.

module tb_apb_timer_ss;

   import timer_pkg::*;

   localparam int unsigned MAX_CYCLES = 20000;   // Well above the sum of all tests

   logic      hclk;
   logic      arst_n;
   apb_req_t  apb_req;
   apb_rsp_t  apb_rsp;
   logic      irq;

   logic [31:0] lcg_state = 32'h21c3_e32e;      // LCG seed
   int unsigned cycles = 0;
   string       cur_test = "reset";
   apb_addr_t   reg_addrs [9] = '{ADDR_CTRL, ADDR_PRESC_LO, ADDR_PRESC_HI, ADDR_CMP_LO,
                                  ADDR_CMP_HI, ADDR_CNT_LO, ADDR_CNT_HI, ADDR_IRQ_STATUS,
                                  ADDR_IRQ_MASK};

   // Reference model state with index 0 for lo and 1 for hi
   logic [2:0] m_ctrl;                           // en_lo, en_hi, cascade
   logic [1:0] m_clr;                            // Pending clear pulses
   presc_t     m_presc [2];
   presc_t     m_div [2];                        // Divider counts
   count_t     m_cmp [2];
   count_t     m_cnt [2];
   logic [1:0] m_status;
   logic [1:0] m_mask;
   logic       m_irq;

   apb_timer_ss dut_i (
      .hclk   (hclk),
      .arst_n (arst_n),
      .apb_req(apb_req),
      .apb_rsp(apb_rsp),
      .irq    (irq)
   );

   initial begin
      hclk = 1'b0;
      forever #2 hclk = ~hclk;                   // Period 4
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Uniform-ish value in 0 .. n-1 from the upper LCG bits
   function automatic logic [31:0] rand_range(input int unsigned n);
      return (lcg_next() >> 8) % n;
   endfunction

   function automatic logic addr_mapped(input apb_addr_t addr);
      foreach (reg_addrs[i]) begin
         if (reg_addrs[i] == addr) return 1'b1;
      end
      return 1'b0;
   endfunction

   // Unmapped address or a write to a read-only count
   function automatic logic slverr_expected(input logic write, input apb_addr_t addr);
      return !addr_mapped(addr) ||
             (write && ((addr == ADDR_CNT_LO) || (addr == ADDR_CNT_HI)));
   endfunction

   function automatic apb_data_t model_read(input apb_addr_t addr);
      case (addr)
         ADDR_CTRL:       return {29'b0, m_ctrl};    // Clear bits never stored
         ADDR_PRESC_LO:   return {24'b0, m_presc[0]};
         ADDR_PRESC_HI:   return {24'b0, m_presc[1]};
         ADDR_CMP_LO:     return m_cmp[0];
         ADDR_CMP_HI:     return m_cmp[1];
         ADDR_CNT_LO:     return m_cnt[0];
         ADDR_CNT_HI:     return m_cnt[1];
         ADDR_IRQ_STATUS: return {30'b0, m_status};
         ADDR_IRQ_MASK:   return {30'b0, m_mask};
         default:         return '0;
      endcase
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else
         fail_run($sformatf("mismatch in %s: %s expected %h actual %h",
                            cur_test, what, exp, act));
   endtask

   task automatic model_reset();
      m_ctrl   = '0;
      m_clr    = '0;
      m_status = '0;
      m_mask   = '0;
      m_irq    = 1'b0;
      for (int ch = 0; ch < 2; ch++) begin
         m_presc[ch] = '0;
         m_div[ch]   = '0;
         m_cmp[ch]   = '0;
         m_cnt[ch]   = '0;
      end
   endtask

   // One rising edge of the whole unit with the write taken from the bus
   task automatic model_step();
      logic       wr;
      logic [1:0] run;
      logic [1:0] tick;
      logic [1:0] step;
      logic [1:0] match;
      logic [1:0] w1c;
      wr = apb_req.psel && apb_req.penable && apb_req.pwrite &&
           !slverr_expected(1'b1, apb_req.paddr);
      for (int ch = 0; ch < 2; ch++) begin
         run[ch]  = m_ctrl[ch] && !m_clr[ch];
         tick[ch] = run[ch] && (m_div[ch] == m_presc[ch]);
      end
      step[0]  = tick[0];
      match[0] = step[0] && (m_cnt[0] == m_cmp[0]);
      step[1]  = m_ctrl[CTRL_CASCADE] ? match[0] : tick[1];   // hi counts lo wraps
      match[1] = step[1] && (m_cnt[1] == m_cmp[1]);
      for (int ch = 0; ch < 2; ch++) begin
         m_div[ch] = (!run[ch] || tick[ch]) ? '0 : m_div[ch] + 8'd1;
         if (m_clr[ch] || match[ch]) begin
            m_cnt[ch] = '0;                      // Clear beats step and a match wraps
         end else if (step[ch]) begin
            m_cnt[ch] = m_cnt[ch] + 32'd1;
         end
      end
      m_irq = |(m_status & m_mask);              // Uses status before this edge
      w1c   = (wr && (apb_req.paddr == ADDR_IRQ_STATUS)) ? apb_req.pwdata[1:0] : 2'b00;
      m_status = (m_status & ~w1c) | match;     // Set wins over clear
      m_clr    = '0;
      if (wr) begin
         case (apb_req.paddr)
            ADDR_CTRL: begin
               m_ctrl = apb_req.pwdata[CTRL_CASCADE:0];
               m_clr  = apb_req.pwdata[CTRL_CLR_HI:CTRL_CLR_LO];
            end
            ADDR_PRESC_LO: m_presc[0] = apb_req.pwdata[7:0];
            ADDR_PRESC_HI: m_presc[1] = apb_req.pwdata[7:0];
            ADDR_CMP_LO:   m_cmp[0]   = apb_req.pwdata;
            ADDR_CMP_HI:   m_cmp[1]   = apb_req.pwdata;
            ADDR_IRQ_MASK: m_mask     = apb_req.pwdata[1:0];
            default:       ;
         endcase
      end
   endtask

   always @(posedge hclk) begin
      if (!arst_n) begin
         model_reset();
      end else begin
         model_step();
      end
   end

   // Registered irq against the model once per cycle
   always @(negedge hclk) begin
      if (arst_n) check_value("irq", {31'b0, m_irq}, {31'b0, irq});
   end

   always @(posedge hclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) fail_run($sformatf("timeout after %0d cycles", cycles));
   end

   // Setup cycle then access cycle with the response checked in the access cycle
   task automatic apb_access(input logic write, input apb_addr_t addr,
                             input apb_data_t wdata);
      logic err_exp;
      err_exp = slverr_expected(write, addr);
      @(negedge hclk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = write ? wdata : '0;
      @(negedge hclk);
      apb_req.penable = 1'b1;
      #1;
      check_value("pready", 32'd1, {31'b0, apb_rsp.pready});
      check_value("pslverr", {31'b0, err_exp}, {31'b0, apb_rsp.pslverr});
      if (!write) begin
         check_value($sformatf("read of %h", addr), model_read(addr), apb_rsp.prdata);
      end
      @(negedge hclk);
      apb_req = '0;                              // Back to idle
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
      apb_access(1'b1, addr, wdata);
   endtask

   task automatic apb_read(input apb_addr_t addr);
      apb_access(1'b0, addr, '0);
   endtask

   task automatic wait_cycles(input int unsigned n);
      repeat (n) @(negedge hclk);
   endtask

   task automatic test_registers();
      cur_test = "registers";
      foreach (reg_addrs[i]) apb_read(reg_addrs[i]);          // All zero after reset
      repeat (8) begin
         apb_write(ADDR_PRESC_LO, lcg_next());
         apb_write(ADDR_PRESC_HI, lcg_next());
         apb_write(ADDR_CMP_LO, lcg_next());
         apb_write(ADDR_CMP_HI, lcg_next());
         apb_write(ADDR_IRQ_MASK, lcg_next());
         for (int i = 1; i < 9; i++) apb_read(reg_addrs[i]);
      end
      repeat (8) begin
         apb_read(apb_addr_t'(12'h024 + rand_range(12'hf00)));   // Past the map
         apb_write(apb_addr_t'(12'h024 + rand_range(12'hf00)), lcg_next());
         apb_write(rand_range(2) ? ADDR_CNT_HI : ADDR_CNT_LO, lcg_next());
         apb_read(ADDR_CNT_LO);
         apb_read(ADDR_CNT_HI);
      end
   endtask

   task automatic test_counting();
      cur_test = "counting";
      for (int ch = 0; ch < 2; ch++) begin
         apb_write(ch ? ADDR_PRESC_HI : ADDR_PRESC_LO, rand_range(8));
         apb_write(ch ? ADDR_CMP_HI : ADDR_CMP_LO, rand_range(12));
         apb_write(ADDR_CTRL, (32'd1 << ch) | (32'd1 << (CTRL_CLR_LO + ch)));
         repeat (25) begin
            wait_cycles(rand_range(20));
            apb_read(ch ? ADDR_CNT_HI : ADDR_CNT_LO);
         end
         apb_write(ADDR_CTRL, 32'd0);
      end
   endtask

   task automatic test_cascade();
      cur_test = "cascade";
      for (int en_hi = 0; en_hi < 2; en_hi++) begin
         apb_write(ADDR_PRESC_LO, rand_range(4));
         apb_write(ADDR_CMP_LO, rand_range(4));                // Frequent lo wraps
         apb_write(ADDR_PRESC_HI, rand_range(4));
         apb_write(ADDR_CMP_HI, 32'd8 + rand_range(24));
         // hi prescaler stopped in the first pass and ticking in the second
         apb_write(ADDR_CTRL, 32'h1d | (32'(en_hi) << CTRL_EN_HI));
         repeat (30) begin
            wait_cycles(rand_range(24));
            apb_read(ADDR_CNT_LO);
            apb_read(ADDR_CNT_HI);
         end
         apb_write(ADDR_CTRL, 32'd0);
      end
   endtask

   task automatic test_status_irq();
      cur_test = "status";
      apb_write(ADDR_IRQ_STATUS, 32'd3);
      apb_write(ADDR_IRQ_MASK, rand_range(4));
      apb_write(ADDR_PRESC_LO, rand_range(4));
      apb_write(ADDR_PRESC_HI, rand_range(4));
      apb_write(ADDR_CMP_LO, rand_range(6));
      apb_write(ADDR_CMP_HI, rand_range(6));
      apb_write(ADDR_CTRL, 32'h1b);                            // Both channels on and restarted
      repeat (20) begin
         wait_cycles(rand_range(16));
         apb_read(ADDR_IRQ_STATUS);
         apb_write(ADDR_IRQ_STATUS, rand_range(4));            // Partial W1C
         apb_read(ADDR_IRQ_STATUS);
         if (rand_range(4) == 0) apb_write(ADDR_IRQ_MASK, rand_range(4));
      end
      apb_write(ADDR_CTRL, 32'd0);
      apb_write(ADDR_IRQ_MASK, 32'd3);
      apb_write(ADDR_IRQ_STATUS, 32'd3);
      apb_read(ADDR_IRQ_STATUS);
      wait_cycles(2);
      check_value("irq after clear", 32'd0, {31'b0, irq});
   endtask

   task automatic test_clear_mixed();
      cur_test = "clear";
      apb_write(ADDR_PRESC_LO, 32'd0);
      apb_write(ADDR_CMP_LO, 32'd1000);
      apb_write(ADDR_PRESC_HI, 32'd1);
      apb_write(ADDR_CMP_HI, 32'd1000);
      apb_write(ADDR_CTRL, 32'd3);
      wait_cycles(40);
      apb_read(ADDR_CNT_LO);
      apb_read(ADDR_CNT_HI);
      apb_write(ADDR_CTRL, 32'h1b);                            // Clear both and keep running
      apb_read(ADDR_CNT_LO);
      apb_read(ADDR_CNT_HI);
      apb_write(ADDR_CTRL, 32'd0);
      apb_read(ADDR_CNT_LO);
      wait_cycles(150);                                        // Disabled counts hold
      apb_read(ADDR_CNT_LO);
      apb_read(ADDR_CNT_HI);
      cur_test = "mixed";
      repeat (200) begin
         case (rand_range(9))
            0: apb_write(ADDR_CTRL, rand_range(32));
            1: apb_write(rand_range(2) ? ADDR_PRESC_HI : ADDR_PRESC_LO, rand_range(6));
            2: apb_write(rand_range(2) ? ADDR_CMP_HI : ADDR_CMP_LO, rand_range(20));
            3: apb_read(reg_addrs[rand_range(9)]);
            4: apb_write(ADDR_IRQ_STATUS, rand_range(4));
            5: apb_write(ADDR_IRQ_MASK, rand_range(4));
            6: wait_cycles(rand_range(30));
            7: apb_write(rand_range(2) ? ADDR_CNT_HI : ADDR_CNT_LO, lcg_next());
            default: apb_read(rand_range(2) ? ADDR_CNT_HI : ADDR_CNT_LO);
         endcase
      end
   endtask

   initial begin
      apb_req = '0;
      arst_n  = 1'b0;
      repeat (4) @(posedge hclk);                // Reset for 4 cycles
      @(negedge hclk);
      arst_n = 1'b1;
      test_registers();
      test_counting();
      test_cascade();
      test_status_irq();
      test_clear_mixed();
      wait_cycles(2);
      $display("TEST OK");
      $finish;
   end

endmodule : tb_apb_timer_ss

// ==== compile.f ====
rtl/timer_pkg.sv
rtl/timer_prescaler.sv
rtl/timer_counter.sv
rtl/timer_apb_regs.sv
rtl/apb_timer_ss.sv
testbench/tb_apb_timer_ss.sv

// ==== Makefile ====
# Verilator build and run of the APB timer testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_timer_ss
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
